//--- adc16_controller.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ADC16 control subsystem on OPB, register block plus two engines.
// Error, retry and timeout-suppress responses are never raised.
// OPB_seqAddr is accepted for bus compatibility and has no effect.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module adc16_controller (
  input  logic                  OPB_Clk,
  input  logic                  rst_n,
  input  adc16_pkg::opb_word_t  OPB_ABus,
  input  adc16_pkg::opb_be_t    OPB_BE,
  input  adc16_pkg::opb_word_t  OPB_DBus,
  input  logic                  OPB_RNW,
  input  logic                  OPB_select,
  input  logic                  OPB_seqAddr,
  output adc16_pkg::opb_word_t  Sl_DBus,
  output logic                  Sl_xferAck,
  output logic                  Sl_errAck,
  output logic                  Sl_retry,
  output logic                  Sl_toutSup,
  output logic                  adc0_adc3wire_clk,
  output logic                  adc0_adc3wire_data,
  output adc16_pkg::cs_mask_t   adc0_adc3wire_cs,      // active low
  output logic                  adc0_reset,
  output adc16_pkg::lane_mask_t adc0_iserdes_bitslip,
  output adc16_pkg::lane_mask_t adc0_load_phase_set,
  output adc16_pkg::dly_mask_t  adc0_delay_rst,
  output adc16_pkg::dly_tap_t   adc0_delay_tap
);

  adc16_pkg::wire3_cmd_t   wire3_cmd;
  adc16_pkg::lane_req_t    lane_req;
  adc16_pkg::ctrl_status_t ctrl_status;
  adc16_pkg::xact_count_t  xact_count;
  logic                    cmd_start;
  logic                    lane_strobe;
  logic                    wire3_busy;
  logic                    reset_busy;

  assign ctrl_status = {wire3_busy, reset_busy, xact_count};  // status word for software

  assign Sl_errAck  = 1'b0;
  assign Sl_retry   = 1'b0;
  assign Sl_toutSup = 1'b0;

  adc16_opb_regs i_adc16_opb_regs (
    .OPB_Clk     (OPB_Clk),
    .rst_n       (rst_n),
    .OPB_ABus    (OPB_ABus),
    .OPB_BE      (OPB_BE),
    .OPB_DBus    (OPB_DBus),
    .OPB_RNW     (OPB_RNW),
    .OPB_select  (OPB_select),
    .ctrl_status (ctrl_status),
    .Sl_DBus     (Sl_DBus),
    .Sl_xferAck  (Sl_xferAck),
    .wire3_cmd   (wire3_cmd),
    .cmd_start   (cmd_start),
    .lane_req    (lane_req),
    .lane_strobe (lane_strobe)
  );

  adc16_wire3_master i_adc16_wire3_master (
    .OPB_Clk    (OPB_Clk),
    .rst_n      (rst_n),
    .wire3_cmd  (wire3_cmd),
    .cmd_start  (cmd_start),
    .sclk       (adc0_adc3wire_clk),
    .sdata      (adc0_adc3wire_data),
    .cs_n       (adc0_adc3wire_cs),
    .busy       (wire3_busy),
    .xact_count (xact_count)
  );

  adc16_lane_ctrl i_adc16_lane_ctrl (
    .OPB_Clk        (OPB_Clk),
    .rst_n          (rst_n),
    .lane_req       (lane_req),
    .lane_strobe    (lane_strobe),
    .bitslip        (adc0_iserdes_bitslip),
    .load_phase_set (adc0_load_phase_set),
    .delay_rst      (adc0_delay_rst),
    .delay_tap      (adc0_delay_tap),
    .chip_reset     (adc0_reset),
    .reset_busy     (reset_busy)
  );

endmodule

//--- adc16_lane_ctrl.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Lane control pulses for the ADC16 deserializers and the chip reset.
// Pulses last one cycle, the cycle after lane_strobe.
// The tap only loads together with a nonzero delay reset mask.
// A reset request during a running reset pulse is dropped.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module adc16_lane_ctrl (
  input  logic                   OPB_Clk,
  input  logic                   rst_n,
  input  adc16_pkg::lane_req_t   lane_req,
  input  logic                   lane_strobe,
  output adc16_pkg::lane_mask_t  bitslip,
  output adc16_pkg::lane_mask_t  load_phase_set,
  output adc16_pkg::dly_mask_t   delay_rst,
  output adc16_pkg::dly_tap_t    delay_tap,
  output logic                   chip_reset,
  output logic                   reset_busy
);

  adc16_pkg::rst_cnt_t rst_cnt_q;  // cycles of chip reset still to run

  always_ff @(posedge OPB_Clk or negedge rst_n) begin
    if (!rst_n) begin
      bitslip        <= '0;
      load_phase_set <= '0;
      delay_rst      <= '0;
      delay_tap      <= '0;
      chip_reset     <= 1'b0;
      rst_cnt_q      <= '0;
    end else begin
      // masks fall back to zero one cycle after the strobe
      bitslip        <= lane_strobe ? lane_req.bitslip : '0;
      load_phase_set <= lane_strobe ? lane_req.load_phase : '0;
      delay_rst      <= lane_strobe ? lane_req.delay_rst : '0;

      if (lane_strobe && (|lane_req.delay_rst)) begin
        delay_tap <= lane_req.delay_tap;  // the idelay samples the tap during its reset
      end

      if (chip_reset) begin
        rst_cnt_q <= rst_cnt_q - 1'b1;
        if (rst_cnt_q == adc16_pkg::rst_cnt_t'(1)) begin
          chip_reset <= 1'b0;  // last cycle of the pulse
        end
      end else if (lane_strobe && lane_req.chip_reset) begin
        chip_reset <= 1'b1;
        rst_cnt_q  <= adc16_pkg::rst_cnt_t'(adc16_pkg::CHIP_RESET_CYCLES);
      end
    end
  end

  assign reset_busy = chip_reset;  // software sees the pulse through status

endmodule

//--- adc16_opb_regs.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// OPB slave for the ADC16 register window, one acknowledge per access.
// Unmapped offsets inside the window ack, read zero and drop writes.
// A CMD write needs all byte enables and an idle serial master to start.
// Strobes and wire3_cmd change in the same cycle as Sl_xferAck.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module adc16_opb_regs (
  input  logic                    OPB_Clk,
  input  logic                    rst_n,
  input  adc16_pkg::opb_word_t    OPB_ABus,
  input  adc16_pkg::opb_be_t      OPB_BE,
  input  adc16_pkg::opb_word_t    OPB_DBus,
  input  logic                    OPB_RNW,
  input  logic                    OPB_select,
  input  adc16_pkg::ctrl_status_t ctrl_status,
  output adc16_pkg::opb_word_t    Sl_DBus,
  output logic                    Sl_xferAck,
  output adc16_pkg::wire3_cmd_t   wire3_cmd,
  output logic                    cmd_start,
  output adc16_pkg::lane_req_t    lane_req,
  output logic                    lane_strobe
);

  adc16_pkg::opb_word_t addr_off;     // address relative to the window base
  adc16_pkg::opb_word_t ctrl_cur;     // ctrl word as it reads back now
  adc16_pkg::opb_word_t ctrl_merged;  // ctrl write after byte enable merge
  adc16_pkg::opb_word_t rd_mux;       // read data selected by offset
  adc16_pkg::opb_word_t rdata_q;      // read data held for the ack cycle
  adc16_pkg::dly_tap_t  tap_q;        // last written tap for readback
  logic                 addr_match;
  logic                 access;
  logic                 wr_cmd;
  logic                 wr_ctrl;
  logic                 cmd_ok;

  assign addr_match = (OPB_ABus >= adc16_pkg::OPB_BASEADDR) &&
                      (OPB_ABus <= adc16_pkg::OPB_HIGHADDR);
  assign addr_off   = OPB_ABus - adc16_pkg::OPB_BASEADDR;

  // the ack term keeps a held select from being taken twice
  assign access  = OPB_select && addr_match && !Sl_xferAck;
  assign wr_cmd  = access && !OPB_RNW && (addr_off == adc16_pkg::REG_CMD);
  assign wr_ctrl = access && !OPB_RNW && (addr_off == adc16_pkg::REG_CTRL);

  // a command needs every byte lane and a master that is not shifting
  assign cmd_ok = (&OPB_BE) && !ctrl_status.wire3_busy;

  // only the tap survives in the ctrl register, the rest self-clears
  assign ctrl_cur = {16'b0, tap_q, 11'b0};

  always_comb begin
    for (int i = 0; i < 4; i++) begin
      ctrl_merged[8*i +: 8] = OPB_BE[i] ? OPB_DBus[8*i +: 8] : ctrl_cur[8*i +: 8];
    end
  end

  always_comb begin
    case (addr_off)
      adc16_pkg::REG_CMD:    rd_mux = {wire3_cmd, 4'b0000};  // last accepted command
      adc16_pkg::REG_CTRL:   rd_mux = ctrl_cur;
      adc16_pkg::REG_STATUS: rd_mux = {ctrl_status.wire3_busy,
                                       ctrl_status.reset_busy,
                                       14'b0,
                                       ctrl_status.xact_count};
      default:               rd_mux = '0;  // unmapped offsets read zero
    endcase
  end

  always_ff @(posedge OPB_Clk or negedge rst_n) begin
    if (!rst_n) begin
      Sl_xferAck  <= 1'b0;
      cmd_start   <= 1'b0;
      lane_strobe <= 1'b0;
      wire3_cmd   <= '0;
      tap_q       <= '0;
    end else begin
      Sl_xferAck  <= access;              // one cycle after select is seen
      cmd_start   <= wr_cmd && cmd_ok;    // rejected commands are acked and lost
      lane_strobe <= wr_ctrl;
      if (wr_cmd && cmd_ok) begin
        wire3_cmd <= adc16_pkg::wire3_cmd_t'(OPB_DBus[0:27]);
      end
      if (wr_ctrl) begin
        tap_q <= ctrl_merged[16:20];      // readback follows every write
      end
    end
  end

  always_ff @(posedge OPB_Clk) begin
    if (access) begin
      rdata_q <= OPB_RNW ? rd_mux : '0;   // writes return an empty bus
    end
    if (wr_ctrl) begin
      lane_req <= adc16_pkg::lane_req_t'(ctrl_merged[0:29]);
    end
  end

  assign Sl_DBus = Sl_xferAck ? rdata_q : '0;  // bus is zero outside the ack cycle

endmodule

//--- adc16_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared types and constants for the ADC16 OPB control subsystem.
// OPB words and ADC-side masks use OPB numbering with bit 0 the MSB.
// The register window, frame timing and reset length are fixed here.
// Counter widths derive from the timing constants and follow any change.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package adc16_pkg;

  typedef logic [0:31] opb_word_t;    // opb address or data word, bit 0 is the msb
  typedef logic [0:3]  opb_be_t;      // byte enables, bit 0 covers bits 0 to 7
  typedef logic [0:3]  cs_mask_t;     // one bit per adc chip, bit 0 is chip 0
  typedef logic [0:3]  lane_mask_t;   // bitslip and phase load select per chip
  typedef logic [0:15] dly_mask_t;    // one bit per idelay line
  typedef logic [0:4]  dly_tap_t;     // idelay tap value, bit 0 is the msb
  typedef logic [15:0] xact_count_t;  // completed 3-wire frames, wraps at 16 bits

  // register window and offsets inside it
  localparam opb_word_t OPB_BASEADDR = 32'h0000_0000;
  localparam opb_word_t OPB_HIGHADDR = 32'h0000_FFFF;
  localparam opb_word_t REG_CMD      = 32'h0000_0000;  // 3-wire command, write starts a frame
  localparam opb_word_t REG_CTRL     = 32'h0000_0004;  // lane control, same layout as before
  localparam opb_word_t REG_STATUS   = 32'h0000_0008;  // busy flags and frame count

  // serial frame timing in OPB_Clk cycles
  localparam int SCLK_HALF         = 2;   // cycles per half serial clock
  localparam int CS_GUARD          = 2;   // chip select to first or last edge
  localparam int CMD_BITS          = 24;  // 8 address bits then 16 data bits
  localparam int CHIP_RESET_CYCLES = 64;  // length of the adc reset pulse

  // counter widths that follow the constants above
  localparam int W3_CNT_W  = $clog2((2 * SCLK_HALF > CS_GUARD) ? 2 * SCLK_HALF : CS_GUARD);
  localparam int BIT_CNT_W = $clog2(CMD_BITS);
  localparam int RST_CNT_W = $clog2(CHIP_RESET_CYCLES + 1);

  typedef logic [W3_CNT_W-1:0]  w3_cnt_t;    // half period and guard counter
  typedef logic [BIT_CNT_W-1:0] bit_cnt_t;   // index of the bit on the wire
  typedef logic [RST_CNT_W-1:0] rst_cnt_t;   // chip reset down-counter
  typedef logic [CMD_BITS-1:0]  w3_frame_t;  // serial frame, msb goes out first

  // command as written to REG_CMD bits 0 to 27
  typedef struct packed {
    cs_mask_t    cs_mask;   // chips that take part in the frame
    logic [7:0]  reg_addr;  // adc register address, sent first
    logic [15:0] reg_data;  // adc register data, sent after the address
  } wire3_cmd_t;

  // lane request, field order matches REG_CTRL bits 0 to 29
  typedef struct packed {
    dly_mask_t  delay_rst;   // idelay reset pulse per line
    dly_tap_t   delay_tap;   // tap loaded together with a delay reset
    lane_mask_t bitslip;     // iserdes bitslip pulse per chip
    lane_mask_t load_phase;  // phase load pulse per chip
    logic       chip_reset;  // starts the timed adc reset
  } lane_req_t;

  // status that the engines return to the register block
  typedef struct packed {
    logic        wire3_busy;  // a serial frame is on the wire
    logic        reset_busy;  // the adc reset pulse is running
    xact_count_t xact_count;  // frames finished since reset
  } ctrl_status_t;

endpackage

//--- adc16_wire3_master.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 3-wire serial master, write only, one 24-bit frame per cmd_start.
// cmd_start is ignored while busy, the register block never sends one then.
// Frame is CS_GUARD lead, CMD_BITS bits of 2*SCLK_HALF, CS_GUARD trail.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module adc16_wire3_master (
  input  logic                   OPB_Clk,
  input  logic                   rst_n,
  input  adc16_pkg::wire3_cmd_t  wire3_cmd,
  input  logic                   cmd_start,
  output logic                   sclk,
  output logic                   sdata,
  output adc16_pkg::cs_mask_t    cs_n,
  output logic                   busy,
  output adc16_pkg::xact_count_t xact_count
);

  typedef enum logic [1:0] {
    ST_IDLE,   // chip selects high, waiting for a command
    ST_LEAD,   // selects low, clock held low before the first bit
    ST_SHIFT,  // bits on the wire
    ST_TRAIL   // clock held low after the last bit
  } w3_state_e;

  w3_state_e            state_q;
  adc16_pkg::w3_cnt_t   cnt_q;    // guard cycles or phase within one bit
  adc16_pkg::bit_cnt_t  bit_q;    // bits already finished in this frame
  adc16_pkg::w3_frame_t shift_q;  // frame being sent, msb on the wire

  // the frame shifts in zeros so data returns low at the end
  assign sdata = shift_q[adc16_pkg::CMD_BITS-1];

  always_ff @(posedge OPB_Clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q    <= ST_IDLE;
      cnt_q      <= '0;
      bit_q      <= '0;
      shift_q    <= '0;
      sclk       <= 1'b0;
      cs_n       <= '1;
      busy       <= 1'b0;
      xact_count <= '0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (cmd_start) begin
            state_q <= ST_LEAD;
            cnt_q   <= '0;
            bit_q   <= '0;
            shift_q <= {wire3_cmd.reg_addr, wire3_cmd.reg_data};  // address goes first
            cs_n    <= ~wire3_cmd.cs_mask;  // only the masked chips are selected
            busy    <= 1'b1;
          end
        end
        ST_LEAD: begin
          if (cnt_q == adc16_pkg::w3_cnt_t'(adc16_pkg::CS_GUARD - 1)) begin
            state_q <= ST_SHIFT;
            cnt_q   <= '0;
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        ST_SHIFT: begin
          cnt_q <= cnt_q + 1'b1;
          if (cnt_q == adc16_pkg::w3_cnt_t'(adc16_pkg::SCLK_HALF - 1)) begin
            sclk <= 1'b1;  // rising edge in the middle of the bit
          end
          if (cnt_q == adc16_pkg::w3_cnt_t'(2 * adc16_pkg::SCLK_HALF - 1)) begin
            sclk    <= 1'b0;  // data moves on together with the falling edge
            cnt_q   <= '0;
            shift_q <= {shift_q[adc16_pkg::CMD_BITS-2:0], 1'b0};
            if (bit_q == adc16_pkg::bit_cnt_t'(adc16_pkg::CMD_BITS - 1)) begin
              state_q <= ST_TRAIL;
            end else begin
              bit_q <= bit_q + 1'b1;
            end
          end
        end
        ST_TRAIL: begin
          if (cnt_q == adc16_pkg::w3_cnt_t'(adc16_pkg::CS_GUARD - 1)) begin
            state_q    <= ST_IDLE;
            cnt_q      <= '0;
            cs_n       <= '1;
            busy       <= 1'b0;
            xact_count <= xact_count + 1'b1;  // counted as the selects release
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        default: begin
          state_q <= ST_IDLE;
        end
      endcase
    end
  end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the ADC16 controller testbench with Verilator and runs it.
set -u
cd "$(dirname "$0")" || exit 1

TOP=tb_adc16_controller
LOG=sim.log

verilator --binary --timing -j 0 --top-module "$TOP" -f sim.f -o "V$TOP"
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/V$TOP > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "Some tests failed" "$LOG"; then
  echo "FAIL: the testbench reported errors"
  exit 1
fi
if [ $run_status -ne 0 ]; then
  echo "FAIL: the simulation exited with status $run_status"
  exit 1
fi
if ! grep -q "All tests passed" "$LOG"; then
  echo "FAIL: the simulation ended without a result"
  exit 1
fi

echo "PASS"
exit 0

//--- sim.f
adc16_pkg.sv
adc16_opb_regs.sv
adc16_wire3_master.sv
adc16_lane_ctrl.sv
adc16_controller.sv
tb_adc16_controller.sv

//--- tb_adc16_controller.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the ADC16 OPB controller, stops at the first error.
// Random stimulus comes from an LCG with seed 48.
// 3-wire frames are checked at the pins against a queue of accepted commands.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module tb_adc16_controller;

  localparam int N_CTRL    = 24;  // random CTRL writes
  localparam int N_FRAMES  = 6;   // random 3-wire commands
  localparam int FRAME_CYC = 2 * adc16_pkg::CS_GUARD +
                             adc16_pkg::CMD_BITS * 2 * adc16_pkg::SCLK_HALF;
  localparam int WATCHDOG_CYC = 16 + 200 + N_CTRL * 16 + (N_FRAMES + 2) * 3 * FRAME_CYC +
                                4 * adc16_pkg::CHIP_RESET_CYCLES + 500;

  logic                  OPB_Clk;
  logic                  rst_n;
  adc16_pkg::opb_word_t  OPB_ABus;
  adc16_pkg::opb_be_t    OPB_BE;
  adc16_pkg::opb_word_t  OPB_DBus;
  logic                  OPB_RNW;
  logic                  OPB_select;
  logic                  OPB_seqAddr;
  adc16_pkg::opb_word_t  Sl_DBus;
  logic                  Sl_xferAck;
  logic                  Sl_errAck;
  logic                  Sl_retry;
  logic                  Sl_toutSup;
  logic                  adc0_adc3wire_clk;
  logic                  adc0_adc3wire_data;
  adc16_pkg::cs_mask_t   adc0_adc3wire_cs;
  logic                  adc0_reset;
  adc16_pkg::lane_mask_t adc0_iserdes_bitslip;
  adc16_pkg::lane_mask_t adc0_load_phase_set;
  adc16_pkg::dly_mask_t  adc0_delay_rst;
  adc16_pkg::dly_tap_t   adc0_delay_tap;

  logic [31:0]           lcg_state;         // random generator state
  logic [23:0]           ack_lanes;         // lane pulses seen in the last ack cycle
  logic                  ack_reset;         // chip reset seen in the last ack cycle
  logic                  cs_idle;           // no chip selected
  logic                  data_prev;         // serial data one cycle ago
  int                    cycle_no = 0;      // free-running cycle count
  int                    reset_cycles = 0;  // cycles with adc0_reset high so far
  int                    frames_seen = 0;   // frames finished at the pins
  adc16_pkg::wire3_cmd_t exp_cmds[$];       // commands the DUT should accept, in order

  assign cs_idle = &adc0_adc3wire_cs;

  adc16_controller i_adc16_controller (.*);

  initial begin : clock_gen
    OPB_Clk = 1'b0;
    forever #5 OPB_Clk = ~OPB_Clk;  // 10 ns period
  end

  task automatic abort_run();
    $display("Some tests failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic abort_with(input string why);
    $display("Error: %s", why);
    abort_run();
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("Mismatch in %s: expected %h, actual %h", name, expected, actual);
      abort_run();
    end
  endtask

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // byte lanes with a clear enable keep the current CTRL content, only the tap is kept
  function automatic adc16_pkg::opb_word_t ctrl_merge(input adc16_pkg::opb_word_t wdata,
                                                      input adc16_pkg::opb_be_t be,
                                                      input adc16_pkg::dly_tap_t tap);
    adc16_pkg::opb_word_t keep;
    adc16_pkg::opb_word_t lanes;
    keep        = '0;
    keep[16:20] = tap;
    lanes       = {{8{be[0]}}, {8{be[1]}}, {8{be[2]}}, {8{be[3]}}};
    return (wdata & lanes) | (keep & ~lanes);
  endfunction

  function automatic adc16_pkg::opb_word_t ctrl_readback(input adc16_pkg::opb_word_t merged);
    return {16'b0, merged[16:20], 11'b0};  // pulse fields self-clear
  endfunction

  function automatic adc16_pkg::w3_frame_t expected_frame(input adc16_pkg::wire3_cmd_t c);
    return {c.reg_addr, c.reg_data};  // address first, msb first
  endfunction

  // one OPB access, select held until the ack or until max_wait cycles pass
  task automatic opb_access(input adc16_pkg::opb_word_t addr, input logic rnw,
                            input adc16_pkg::opb_be_t be, input adc16_pkg::opb_word_t wdata,
                            input int max_wait, output adc16_pkg::opb_word_t rdata,
                            output logic acked);
    int waited;
    waited = 0;
    acked  = 1'b0;
    rdata  = '0;
    @(posedge OPB_Clk);
    OPB_ABus   <= addr;
    OPB_RNW    <= rnw;
    OPB_BE     <= be;
    OPB_DBus   <= rnw ? '0 : wdata;
    OPB_select <= 1'b1;
    while (!acked && waited < max_wait) begin
      @(negedge OPB_Clk);  // ack and read data are settled mid-cycle
      waited++;
      if (Sl_xferAck) begin
        acked     = 1'b1;
        rdata     = Sl_DBus;
        ack_lanes = {adc0_iserdes_bitslip, adc0_load_phase_set, adc0_delay_rst};
        ack_reset = adc0_reset;
      end
    end
    @(posedge OPB_Clk);
    OPB_select <= 1'b0;
  endtask

  task automatic opb_write(input adc16_pkg::opb_word_t addr, input adc16_pkg::opb_be_t be,
                           input adc16_pkg::opb_word_t data);
    adc16_pkg::opb_word_t ignored;
    logic                 acked;
    opb_access(addr, 1'b0, be, data, 8, ignored, acked);
    if (!acked) abort_with($sformatf("write to %h got no acknowledge", addr));
  endtask

  task automatic opb_read(input adc16_pkg::opb_word_t addr, output adc16_pkg::opb_word_t data);
    logic acked;
    opb_access(addr, 1'b1, 4'hF, '0, 8, data, acked);
    if (!acked) abort_with($sformatf("read from %h got no acknowledge", addr));
  endtask

  always @(negedge OPB_Clk) begin
    cycle_no <= cycle_no + 1;
    if (adc0_reset) reset_cycles <= reset_cycles + 1;
    if (rst_n && adc0_adc3wire_clk && (adc0_adc3wire_data !== data_prev)) begin
      abort_with("3-wire data changed while the serial clock was high");
    end
    data_prev <= adc0_adc3wire_data;
  end

  // captures each frame at the pins and compares it with the next accepted command
  initial begin : frame_monitor
    adc16_pkg::w3_frame_t  cap_bits;
    adc16_pkg::wire3_cmd_t exp;
    adc16_pkg::cs_mask_t   cs_sel;
    int                    cap_n;
    int                    t_start;
    forever begin
      @(negedge cs_idle);
      if (frames_seen >= exp_cmds.size()) abort_with("a 3-wire frame started unrequested");
      exp      = exp_cmds[frames_seen];
      cs_sel   = ~adc0_adc3wire_cs;
      t_start  = cycle_no;
      cap_n    = 0;
      cap_bits = '0;
      while (!cs_idle) begin
        @(posedge adc0_adc3wire_clk or posedge cs_idle);
        if (adc0_adc3wire_clk && !cs_idle) begin
          cap_bits = {cap_bits[adc16_pkg::CMD_BITS-2:0], adc0_adc3wire_data};
          cap_n++;
        end
      end
      check_value("frame bits", 32'(expected_frame(exp)), 32'(cap_bits));
      check_value("frame bit count", adc16_pkg::CMD_BITS, cap_n);
      check_value("frame chip selects", 32'(exp.cs_mask), 32'(cs_sel));
      check_value("frame length", FRAME_CYC, cycle_no - t_start);  // equals busy time
      frames_seen++;
    end
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYC) @(posedge OPB_Clk);
    abort_with("watchdog expired before the tests finished");
  end

  initial begin : main
    adc16_pkg::opb_word_t  rd;
    adc16_pkg::opb_word_t  wd;
    adc16_pkg::opb_word_t  merged;
    adc16_pkg::opb_be_t    be;
    adc16_pkg::wire3_cmd_t cmd;
    adc16_pkg::dly_tap_t   rb_tap;
    adc16_pkg::dly_tap_t   out_tap;
    logic                  acked;
    int                    n_done;
    int                    polls;
    int                    rst_base;
    lcg_state   = 32'd48;
    rst_n       = 1'b0;
    OPB_ABus    = '0;
    OPB_BE      = '0;
    OPB_DBus    = '0;
    OPB_RNW     = 1'b1;
    OPB_select  = 1'b0;
    OPB_seqAddr = 1'b0;
    repeat (16) @(posedge OPB_Clk);
    rst_n <= 1'b1;

    // reset values and address decode
    @(negedge OPB_Clk);
    check_value("reset chip selects", 32'hF, 32'(adc0_adc3wire_cs));
    check_value("reset pins", 0, 32'({adc0_adc3wire_clk, adc0_adc3wire_data, adc0_reset,
                                      Sl_xferAck, Sl_errAck, Sl_retry, Sl_toutSup}));
    check_value("reset lanes", 0, 32'({adc0_iserdes_bitslip, adc0_load_phase_set,
                                       adc0_delay_rst}));
    check_value("reset tap", 0, 32'(adc0_delay_tap));
    check_value("idle read bus", 0, Sl_DBus);
    opb_read(adc16_pkg::REG_CTRL, rd);
    check_value("reset ctrl", 0, rd);
    opb_read(adc16_pkg::REG_STATUS, rd);
    check_value("reset status", 0, rd);
    opb_write(32'h0000_000C, 4'hF, 32'hFFFF_FFFF);  // unmapped, dropped
    opb_read(32'h0000_000C, rd);
    check_value("unmapped read", 0, rd);
    opb_access(adc16_pkg::OPB_HIGHADDR + 32'd4, 1'b1, 4'hF, '0, 8, rd, acked);
    check_value("out of window ack", 0, 32'(acked));

    // CTRL merge, readback and lane pulses
    rb_tap  = '0;
    out_tap = '0;
    for (int k = 0; k < N_CTRL; k++) begin
      wd     = lcg_next();
      be     = adc16_pkg::opb_be_t'(lcg_next() >> 28);
      wd[29] = 1'b0;                      // chip reset is tested on its own
      if (k % 3 == 0) wd[0:15] = '0;      // these writes must leave the port tap alone
      merged = ctrl_merge(wd, be, rb_tap);
      opb_write(adc16_pkg::REG_CTRL, be, wd);
      check_value("lane pulses in ack cycle", 0, 32'(ack_lanes));
      @(negedge OPB_Clk);                 // the cycle after the ack
      if (|merged[0:15]) out_tap = merged[16:20];
      rb_tap = merged[16:20];
      check_value("bitslip pulse", 32'(merged[21:24]), 32'(adc0_iserdes_bitslip));
      check_value("load phase pulse", 32'(merged[25:28]), 32'(adc0_load_phase_set));
      check_value("delay reset pulse", 32'(merged[0:15]), 32'(adc0_delay_rst));
      check_value("delay tap", 32'(out_tap), 32'(adc0_delay_tap));
      @(negedge OPB_Clk);
      check_value("lane pulses after", 0, 32'({adc0_iserdes_bitslip, adc0_load_phase_set,
                                               adc0_delay_rst}));
      opb_read(adc16_pkg::REG_CTRL, rd);
      check_value("ctrl readback", ctrl_readback(merged), rd);
    end

    // serial frames, with one write dropped while busy
    n_done = 0;
    for (int k = 0; k < N_FRAMES; k++) begin
      cmd = adc16_pkg::wire3_cmd_t'(28'(lcg_next() >> 4));
      if (cmd.cs_mask == '0) cmd.cs_mask = 4'b1000;  // at least one chip takes part
      exp_cmds.push_back(cmd);
      opb_write(adc16_pkg::REG_CMD, 4'hF, {cmd, 4'b0000});
      opb_read(adc16_pkg::REG_STATUS, rd);
      check_value("busy during frame", 1, 32'(rd[0]));
      if (k == 1) opb_write(adc16_pkg::REG_CMD, 4'hF, ~{cmd, 4'b0000});
      polls = 0;
      do begin
        opb_read(adc16_pkg::REG_STATUS, rd);
        polls++;
        if (polls > FRAME_CYC) abort_with("wire3_busy never cleared");
      end while (rd[0]);
      n_done++;
      check_value("xact count", n_done, 32'(rd[16:31]));
      check_value("frames seen", n_done, frames_seen);
      opb_read(adc16_pkg::REG_CMD, rd);
      check_value("last accepted command", {cmd, 4'b0000}, rd);
    end

    // partial byte enables never start a frame
    opb_write(adc16_pkg::REG_CMD, 4'b1110, ~{cmd, 4'b0000});
    repeat (FRAME_CYC) @(negedge OPB_Clk);
    opb_read(adc16_pkg::REG_STATUS, rd);
    check_value("status after partial write", n_done, rd);
    check_value("frames left over", exp_cmds.size(), frames_seen);

    // chip reset pulse, a second request during it is ignored
    wd     = '0;
    wd[29] = 1'b1;
    rst_base = reset_cycles;
    opb_write(adc16_pkg::REG_CTRL, 4'b0001, wd);
    check_value("chip reset in ack cycle", 0, 32'(ack_reset));
    @(negedge OPB_Clk);
    check_value("chip reset start", 1, 32'(adc0_reset));
    opb_read(adc16_pkg::REG_STATUS, rd);
    check_value("reset busy", 1, 32'(rd[1]));
    opb_write(adc16_pkg::REG_CTRL, 4'b0001, wd);
    polls = 0;
    while (adc0_reset) begin
      @(negedge OPB_Clk);
      polls++;
      if (polls > 2 * adc16_pkg::CHIP_RESET_CYCLES) abort_with("adc0_reset never fell");
    end
    check_value("chip reset length", adc16_pkg::CHIP_RESET_CYCLES, reset_cycles - rst_base);
    opb_read(adc16_pkg::REG_STATUS, rd);
    check_value("reset busy after pulse", 0, 32'(rd[1]));

    $display("All tests passed");
    $finish;
  end

endmodule
